// ==== hw/memWrDma_params.svh ====
// Widths, FIFO depth and register map of the memory-write DMA engine
// Transfers are qword granular, so every address and length is a multiple of 8
`ifndef MEMWRDMA_PARAMS_SVH
`define MEMWRDMA_PARAMS_SVH

`define MWD_HOST_AW      64
`define MWD_LCL_AW       32
`define MWD_LINE_W       64
`define MWD_LEN_W        10    // TLP length field in dwords
`define MWD_PLD_W        12    // Payload byte count, 4096 not supported
`define MWD_FIFO_DEPTH   64    // Lines, one 512-byte packet
`define MWD_BNDRY_BYTES  128   // Host boundary that ends a packet

// Configuration register addresses
`define MWD_REG_CTRL     4'h0
`define MWD_REG_STAT     4'h1
`define MWD_REG_HADDR_LO 4'h4
`define MWD_REG_HADDR_HI 4'h5
`define MWD_REG_LADDR    4'h6
`define MWD_REG_LEN      4'h7

`endif

// ==== hw/memWrDma_pkg.sv ====
// Shared types of the DMA engine
// Field widths follow the parameter header
`default_nettype none
`include "memWrDma_params.svh"

package memWrDma_pkg;

	typedef logic [`MWD_HOST_AW-1:0] hostAddr_t;
	typedef logic [`MWD_LCL_AW-1:0]  lclAddr_t;
	typedef logic [`MWD_LINE_W-1:0]  line_t;
	typedef logic [31:0]             cfgData_t;
	typedef logic [31:0]             byteCnt_t;
	typedef logic [`MWD_PLD_W-1:0]   pload_t;
	typedef logic [`MWD_LEN_W-1:0]   dwLen_t;
	typedef logic [7:0]              tag_t;
	typedef logic [15:0]             reqId_t;

	// Transfer as programmed by software
	typedef struct packed {
		hostAddr_t hostBase;
		lclAddr_t  lclBase;
		byteCnt_t  byteCnt;
	} xferCfg_t;

	// One packet handed from the segmenter to the reader and framer
	typedef struct packed {
		hostAddr_t hostAddr;
		lclAddr_t  lclAddr;
		pload_t    pload;   // Bytes
		dwLen_t    dwLen;
		tag_t      tag;
	} pktDesc_t;

	typedef enum logic [1:0] {SEG_IDLE, SEG_ISSUE, SEG_WAIT} segState_t;

	typedef enum logic [1:0] {FRM_IDLE, FRM_HDR0, FRM_HDR1, FRM_DATA} frmState_t;

endpackage

`default_nettype wire

// ==== hw/dmaCfgRegs.sv ====
// Configuration registers with a one-cycle ack per strobe
// Writes to registers 4 to 7 are dropped while the engine is busy
`default_nettype none
`include "memWrDma_params.svh"

module dmaCfgRegs
(
	input  wire                           i_CfgClk,
	input  wire                           i_ARst,
	input  wire                           i_CfgCyc,
	input  wire                           i_CfgStb,
	input  wire                           i_CfgWnR,
	input  wire [3:0]                     i_CfgAddr,
	input  wire memWrDma_pkg::cfgData_t   i_CfgWrData,
	input  wire                           i_Busy,
	input  wire                           i_Done,
	input  wire memWrDma_pkg::byteCnt_t   i_Remain,
	output logic                          o_CfgAck,
	output memWrDma_pkg::cfgData_t        o_CfgRdData,
	output memWrDma_pkg::xferCfg_t        o_XferCfg,
	output logic                          o_Start
);

	memWrDma_pkg::cfgData_t ctrlReg;   // Bit 0 is the enable
	logic wrEn;
	logic xferWrEn;

	assign wrEn     = i_CfgCyc & i_CfgStb & i_CfgWnR & ~o_CfgAck;   // First edge only
	assign xferWrEn = wrEn & ~i_Busy;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			o_CfgAck  <= 1'b0;
			o_Start   <= 1'b0;
			ctrlReg   <= '0;
			o_XferCfg <= '0;
		end
		else
		begin
			o_CfgAck <= i_CfgCyc & i_CfgStb & ~o_CfgAck;
			// Byte count write kicks off the transfer when enabled
			o_Start  <= xferWrEn && (i_CfgAddr == `MWD_REG_LEN) && ctrlReg[0];
			if (wrEn && (i_CfgAddr == `MWD_REG_CTRL))
				ctrlReg <= i_CfgWrData;
			if (xferWrEn)
			begin
				case (i_CfgAddr)
					`MWD_REG_HADDR_LO: o_XferCfg.hostBase[31:0]  <= i_CfgWrData;
					`MWD_REG_HADDR_HI: o_XferCfg.hostBase[63:32] <= i_CfgWrData;
					`MWD_REG_LADDR:    o_XferCfg.lclBase         <= i_CfgWrData;
					`MWD_REG_LEN:      o_XferCfg.byteCnt         <= i_CfgWrData;
					default:           ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Readback, valid while ack is high
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (i_CfgAddr)
			`MWD_REG_CTRL:     o_CfgRdData = ctrlReg;
			`MWD_REG_STAT:     o_CfgRdData = {30'd0, i_Done, i_Busy};
			`MWD_REG_HADDR_LO: o_CfgRdData = o_XferCfg.hostBase[31:0];
			`MWD_REG_HADDR_HI: o_CfgRdData = o_XferCfg.hostBase[63:32];
			`MWD_REG_LADDR:    o_CfgRdData = o_XferCfg.lclBase;
			`MWD_REG_LEN:      o_CfgRdData = i_Remain;   // Remaining, not programmed
			default:           o_CfgRdData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/pktSegmenter.sv ====
// Cuts a transfer into packets that never cross a 128-byte host boundary
// Only one packet is in flight, the next waits for the framer to go idle
`default_nettype none
`include "memWrDma_params.svh"

module pktSegmenter
(
	input  wire                           i_CfgClk,
	input  wire                           i_ARst,
	input  wire memWrDma_pkg::xferCfg_t   i_XferCfg,
	input  wire                           i_Start,
	input  wire memWrDma_pkg::pload_t     i_MaxPload,
	input  wire                           i_FrmBusy,
	output logic                          o_DescStb,
	output memWrDma_pkg::pktDesc_t        o_Desc,
	output logic                          o_Busy,
	output logic                          o_Done,
	output memWrDma_pkg::byteCnt_t        o_Remain
);

	localparam int BndryBits = $clog2(`MWD_BNDRY_BYTES);

	memWrDma_pkg::segState_t state;
	memWrDma_pkg::hostAddr_t hostAddr;
	memWrDma_pkg::lclAddr_t  lclAddr;
	memWrDma_pkg::tag_t      tagCnt;
	memWrDma_pkg::pload_t    bndDist;
	memWrDma_pkg::pload_t    remCap;
	memWrDma_pkg::pload_t    pktSize;
	memWrDma_pkg::byteCnt_t  pktBytes;
	logic loadNow;
	logic issueNow;
	logic advanceNow;

	assign loadNow    = (state == memWrDma_pkg::SEG_IDLE) && i_Start;
	assign issueNow   = (state == memWrDma_pkg::SEG_ISSUE) && !i_FrmBusy;
	assign advanceNow = (state == memWrDma_pkg::SEG_WAIT) && !i_FrmBusy;
	assign pktBytes   = memWrDma_pkg::byteCnt_t'(o_Desc.pload);

	// Size is the smallest of boundary distance, max payload and remainder
	always_comb
	begin
		bndDist = memWrDma_pkg::pload_t'(`MWD_BNDRY_BYTES)
			- memWrDma_pkg::pload_t'(hostAddr[BndryBits-1:0]);
		if (o_Remain > memWrDma_pkg::byteCnt_t'(i_MaxPload))
			remCap = i_MaxPload;
		else
			remCap = o_Remain[`MWD_PLD_W-1:0];
		pktSize = (bndDist < remCap) ? bndDist : remCap;
	end

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			state     <= memWrDma_pkg::SEG_IDLE;
			o_DescStb <= 1'b0;
			o_Remain  <= '0;
			tagCnt    <= '0;
		end
		else
		begin
			o_DescStb <= issueNow;
			if (issueNow)
				tagCnt <= tagCnt + 1'b1;   // Wraps at 8 bits
			case (state)
				memWrDma_pkg::SEG_IDLE:
					if (i_Start)
					begin
						o_Remain <= i_XferCfg.byteCnt;
						if (i_XferCfg.byteCnt != '0)   // Zero length sends nothing
							state <= memWrDma_pkg::SEG_ISSUE;
					end
				memWrDma_pkg::SEG_ISSUE:
					if (issueNow)
						state <= memWrDma_pkg::SEG_WAIT;
				memWrDma_pkg::SEG_WAIT:
					if (advanceNow)
					begin
						o_Remain <= o_Remain - pktBytes;
						if (o_Remain == pktBytes)
							state <= memWrDma_pkg::SEG_IDLE;
						else
							state <= memWrDma_pkg::SEG_ISSUE;
					end
				default:
					state <= memWrDma_pkg::SEG_IDLE;
			endcase
		end
	end

	// Addresses and descriptor
	always_ff @(posedge i_CfgClk)
	begin
		if (loadNow)
		begin
			hostAddr <= i_XferCfg.hostBase;
			lclAddr  <= i_XferCfg.lclBase;
		end
		else if (advanceNow)
		begin
			hostAddr <= hostAddr + memWrDma_pkg::hostAddr_t'(o_Desc.pload);
			lclAddr  <= lclAddr + memWrDma_pkg::lclAddr_t'(o_Desc.pload);
		end
		if (issueNow)
		begin
			o_Desc.hostAddr <= hostAddr;
			o_Desc.lclAddr  <= lclAddr;
			o_Desc.pload    <= pktSize;
			o_Desc.dwLen    <= pktSize[`MWD_PLD_W-1:2];
			o_Desc.tag      <= tagCnt;
		end
	end

	assign o_Busy = (state != memWrDma_pkg::SEG_IDLE);
	assign o_Done = (state == memWrDma_pkg::SEG_IDLE) && (o_Remain == '0);

endmodule

`default_nettype wire

// ==== hw/memBurstReader.sv ====
// Burst reads of one packet's lines from local memory
// Read level holds until payload/8 reads are accepted
`default_nettype none
`include "memWrDma_params.svh"

module memBurstReader
(
	input  wire                           i_CfgClk,
	input  wire                           i_ARst,
	input  wire                           i_DescStb,
	input  wire memWrDma_pkg::pktDesc_t   i_Desc,
	input  wire                           i_MemReady,
	output logic                          o_MemRd,
	output memWrDma_pkg::lclAddr_t        o_MemRdAddr
);

	localparam int LineBytes = `MWD_LINE_W / 8;
	localparam int ByteBits  = $clog2(LineBytes);
	localparam int CntW      = `MWD_PLD_W - ByteBits;

	logic [CntW-1:0] linesLeft;
	logic            rdAccept;

	assign rdAccept = o_MemRd & i_MemReady;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			o_MemRd   <= 1'b0;
			linesLeft <= '0;
		end
		else if (i_DescStb)
		begin
			linesLeft <= i_Desc.pload[`MWD_PLD_W-1:ByteBits];
			o_MemRd   <= (i_Desc.pload[`MWD_PLD_W-1:ByteBits] != '0);
		end
		else if (rdAccept)
		begin
			linesLeft <= linesLeft - 1'b1;
			if (linesLeft == CntW'(1))   // Last read accepted
				o_MemRd <= 1'b0;
		end
	end

	always_ff @(posedge i_CfgClk)
	begin
		if (i_DescStb)
			o_MemRdAddr <= i_Desc.lclAddr;
		else if (rdAccept)
			o_MemRdAddr <= o_MemRdAddr + memWrDma_pkg::lclAddr_t'(LineBytes);
	end

endmodule

`default_nettype wire

// ==== hw/lineFifo.sv ====
// Look-ahead FIFO of data lines, head visible while not empty
// DEPTH must be a power of two
`default_nettype none

module lineFifo
#(
	parameter int DEPTH = 16
)
(
	input  wire                         i_CfgClk,
	input  wire                         i_ARst,
	input  wire                         i_Wr,
	input  wire memWrDma_pkg::line_t    i_Din,
	input  wire                         i_Rd,
	output memWrDma_pkg::line_t         o_Dout,
	output logic                        o_Empty
);

	localparam int AddrW = $clog2(DEPTH);

	memWrDma_pkg::line_t mem [DEPTH];
	logic [AddrW-1:0] wrPtr;
	logic [AddrW-1:0] rdPtr;
	logic [AddrW:0]   count;
	logic             doWr;
	logic             doRd;

	assign doWr    = i_Wr && (count != (AddrW+1)'(DEPTH));   // Drop on full
	assign doRd    = i_Rd && !o_Empty;
	assign o_Empty = (count == '0);
	assign o_Dout  = mem[rdPtr];

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= wrPtr + 1'b1;
			if (doRd)
				rdPtr <= rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_CfgClk)
	begin
		if (doWr)
			mem[wrPtr] <= i_Din;
	end

endmodule

`default_nettype wire

// ==== hw/tlpFramer.sv ====
// Frames memory-write TLPs on the Avalon-ST port
// 3DW headers below 4 GB, data dword 0 rides in the second header line
// Both byte enables are all ones since transfers are qword granular
`default_nettype none
`include "memWrDma_params.svh"

module tlpFramer
(
	input  wire                           i_CfgClk,
	input  wire                           i_ARst,
	input  wire                           i_DescStb,
	input  wire memWrDma_pkg::pktDesc_t   i_Desc,
	input  wire memWrDma_pkg::reqId_t     i_ReqId,
	input  wire memWrDma_pkg::line_t      i_FifoData,
	input  wire                           i_FifoEmpty,
	input  wire                           i_AstTxReady,
	output logic                          o_FifoRd,
	output logic                          o_FrmBusy,
	output logic                          o_AstTxDv,
	output logic                          o_AstTxSop,
	output logic                          o_AstTxEop,
	output memWrDma_pkg::line_t           o_AstTxData
);

	localparam int CntW = `MWD_PLD_W - 3;   // Qword lines per packet

	memWrDma_pkg::frmState_t state;
	logic [CntW-1:0] dataLeft;
	logic [31:0]     heldDw;     // Upper dword carried to the next line
	logic [31:0]     dw0;
	logic [31:0]     dw1;
	logic [31:0]     addrLo;
	logic            is4Dw;
	logic            lastLine;
	logic            needFifo;
	logic            accept;

	assign is4Dw  = |i_Desc.hostAddr[63:32];
	assign addrLo = i_Desc.hostAddr[31:0];
	// Fmt 1x, type 0, TC 0, no digest or poison
	assign dw0 = {1'b0, 1'b1, is4Dw, 5'd0, 8'd0, 6'd0, i_Desc.dwLen};
	assign dw1 = {i_ReqId, i_Desc.tag, 4'hF, 4'hF};
	assign lastLine = (state == memWrDma_pkg::FRM_DATA) && (dataLeft == CntW'(1));

	////////////////////////////////////////////////////////////////////////////
	// Line mux, holds while ready is low since the FIFO head does not move
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		needFifo    = 1'b0;
		o_AstTxData = i_FifoData;
		case (state)
			memWrDma_pkg::FRM_HDR0:
				o_AstTxData = {dw1, dw0};
			memWrDma_pkg::FRM_HDR1:
				if (is4Dw)
					o_AstTxData = {addrLo, i_Desc.hostAddr[63:32]};
				else
				begin
					needFifo    = 1'b1;
					o_AstTxData = {i_FifoData[31:0], addrLo};
				end
			memWrDma_pkg::FRM_DATA:
				if (is4Dw)
					needFifo = 1'b1;
				else if (lastLine)
					o_AstTxData = {32'd0, heldDw};   // Single dword left
				else
				begin
					needFifo    = 1'b1;
					o_AstTxData = {i_FifoData[31:0], heldDw};
				end
			default: ;
		endcase
	end

	assign o_AstTxDv  = (state != memWrDma_pkg::FRM_IDLE) && !(needFifo && i_FifoEmpty);
	assign o_AstTxSop = (state == memWrDma_pkg::FRM_HDR0);
	assign o_AstTxEop = lastLine && o_AstTxDv;
	assign accept     = o_AstTxDv && i_AstTxReady;
	assign o_FifoRd   = accept && needFifo;
	assign o_FrmBusy  = i_DescStb || (state != memWrDma_pkg::FRM_IDLE);

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			state    <= memWrDma_pkg::FRM_IDLE;
			dataLeft <= '0;
		end
		else
		begin
			case (state)
				memWrDma_pkg::FRM_IDLE:
					if (i_DescStb)
					begin
						state    <= memWrDma_pkg::FRM_HDR0;
						dataLeft <= i_Desc.pload[`MWD_PLD_W-1:3];
					end
				memWrDma_pkg::FRM_HDR0:
					if (accept)
						state <= memWrDma_pkg::FRM_HDR1;
				memWrDma_pkg::FRM_HDR1:
					if (accept)
						state <= memWrDma_pkg::FRM_DATA;
				memWrDma_pkg::FRM_DATA:
					if (accept)
					begin
						dataLeft <= dataLeft - 1'b1;
						if (lastLine)
							state <= memWrDma_pkg::FRM_IDLE;
					end
				default:
					state <= memWrDma_pkg::FRM_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_CfgClk)
	begin
		if (o_FifoRd)
			heldDw <= i_FifoData[63:32];
	end

endmodule

`default_nettype wire

// ==== hw/memWrDma.sv ====
// Local to host memory-write DMA engine, all logic on i_CfgClk
// Host address, local address and length must be multiples of 8
// i_MaxPload is a multiple of 128 from 128 to 512
`default_nettype none
`include "memWrDma_params.svh"

module memWrDma
(
	input  wire                           i_CfgClk,
	input  wire                           i_ARst,
	// Configuration bus
	input  wire                           i_CfgCyc,
	input  wire                           i_CfgStb,
	input  wire                           i_CfgWnR,
	input  wire [3:0]                     i_CfgAddr,
	input  wire memWrDma_pkg::cfgData_t   i_CfgWrData,
	output wire                           o_CfgAck,
	output memWrDma_pkg::cfgData_t        o_CfgRdData,
	input  wire memWrDma_pkg::pload_t     i_MaxPload,
	input  wire memWrDma_pkg::reqId_t     i_RequesterId,
	// Local memory
	output wire                           o_MemRd,
	output memWrDma_pkg::lclAddr_t        o_MemRdAddr,
	input  wire                           i_MemReady,
	input  wire                           i_MemDv,
	input  wire memWrDma_pkg::line_t      i_MemRdData,
	// Avalon-ST transmit
	output wire                           o_AstTxDv,
	output wire                           o_AstTxSop,
	output wire                           o_AstTxEop,
	output memWrDma_pkg::line_t           o_AstTxData,
	input  wire                           i_AstTxReady
);

	memWrDma_pkg::xferCfg_t xferCfg;
	memWrDma_pkg::byteCnt_t remain;
	memWrDma_pkg::pktDesc_t desc;
	memWrDma_pkg::line_t    fifoData;
	logic start;
	logic busy;
	logic done;
	logic descStb;
	logic frmBusy;
	logic fifoEmpty;
	logic fifoRd;

	dmaCfgRegs u_cfgRegs
	(
		.i_CfgClk    (i_CfgClk),
		.i_ARst      (i_ARst),
		.i_CfgCyc    (i_CfgCyc),
		.i_CfgStb    (i_CfgStb),
		.i_CfgWnR    (i_CfgWnR),
		.i_CfgAddr   (i_CfgAddr),
		.i_CfgWrData (i_CfgWrData),
		.i_Busy      (busy),
		.i_Done      (done),
		.i_Remain    (remain),
		.o_CfgAck    (o_CfgAck),
		.o_CfgRdData (o_CfgRdData),
		.o_XferCfg   (xferCfg),
		.o_Start     (start)
	);

	pktSegmenter u_segmenter
	(
		.i_CfgClk   (i_CfgClk),
		.i_ARst     (i_ARst),
		.i_XferCfg  (xferCfg),
		.i_Start    (start),
		.i_MaxPload (i_MaxPload),
		.i_FrmBusy  (frmBusy),
		.o_DescStb  (descStb),
		.o_Desc     (desc),
		.o_Busy     (busy),
		.o_Done     (done),
		.o_Remain   (remain)
	);

	memBurstReader u_reader
	(
		.i_CfgClk    (i_CfgClk),
		.i_ARst      (i_ARst),
		.i_DescStb   (descStb),
		.i_Desc      (desc),
		.i_MemReady  (i_MemReady),
		.o_MemRd     (o_MemRd),
		.o_MemRdAddr (o_MemRdAddr)
	);

	// Read data lands here in order, one line per valid
	lineFifo #(.DEPTH(`MWD_FIFO_DEPTH)) u_lineFifo
	(
		.i_CfgClk (i_CfgClk),
		.i_ARst   (i_ARst),
		.i_Wr     (i_MemDv),
		.i_Din    (i_MemRdData),
		.i_Rd     (fifoRd),
		.o_Dout   (fifoData),
		.o_Empty  (fifoEmpty)
	);

	tlpFramer u_framer
	(
		.i_CfgClk     (i_CfgClk),
		.i_ARst       (i_ARst),
		.i_DescStb    (descStb),
		.i_Desc       (desc),
		.i_ReqId      (i_RequesterId),
		.i_FifoData   (fifoData),
		.i_FifoEmpty  (fifoEmpty),
		.i_AstTxReady (i_AstTxReady),
		.o_FifoRd     (fifoRd),
		.o_FrmBusy    (frmBusy),
		.o_AstTxDv    (o_AstTxDv),
		.o_AstTxSop   (o_AstTxSop),
		.o_AstTxEop   (o_AstTxEop),
		.o_AstTxData  (o_AstTxData)
	);

endmodule

`default_nettype wire

// ==== bench/tbMemWrDma_assertions.sv ====
// Stream and memory port properties of memWrDma, attached with bind
// Failures are counted in failCount for the testbench summary
`default_nettype none

module tbMemWrDma_assertions
(
	input wire                        i_Clk,
	input wire                        i_ARst,
	input wire                        i_MemRd,
	input wire                        i_TxDv,
	input wire                        i_TxSop,
	input wire                        i_TxEop,
	input wire memWrDma_pkg::line_t   i_TxData,
	input wire                        i_TxReady
);

	int   failCount = 0;
	logic inPkt;      // Between an accepted Sop and its Eop
	logic txAccept;

	assign txAccept = i_TxDv && i_TxReady;

	always_ff @(posedge i_Clk or posedge i_ARst)
	begin
		if (i_ARst)
			inPkt <= 1'b0;
		else if (txAccept && i_TxSop)
			inPkt <= 1'b1;
		else if (txAccept && i_TxEop)
			inPkt <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stream holds under back-pressure
	////////////////////////////////////////////////////////////////////////////
	holdOnStall: assert property (@(posedge i_Clk) disable iff (i_ARst)
		(i_TxDv && !i_TxReady) |=> (i_TxDv && $stable(i_TxSop) && $stable(i_TxEop)
			&& $stable(i_TxData)))
	else
	begin
		failCount++;
		$error("Stream changed while ready was low");
	end

	sopOutsidePkt: assert property (@(posedge i_Clk) disable iff (i_ARst)
		(txAccept && i_TxSop) |-> !inPkt)
	else
	begin
		failCount++;
		$error("Sop accepted inside a packet");
	end

	eopInsidePkt: assert property (@(posedge i_Clk) disable iff (i_ARst)
		(txAccept && i_TxEop) |-> inPkt)
	else
	begin
		failCount++;
		$error("Eop accepted without a Sop");
	end

	// Quiet ports right after reset
	idleAfterReset: assert property (@(posedge i_Clk) $fell(i_ARst) |-> (!i_MemRd && !i_TxDv))
	else
	begin
		failCount++;
		$error("Memory read or stream valid high after reset");
	end

endmodule

`default_nettype wire

// ==== bench/tbMemWrDma.sv ====
// Random transfers below and above 4 GB, with and without back-pressure
// Memory returns {addr, ~addr} per line after 1 to 4 cycles
`default_nettype none
`include "memWrDma_params.svh"

module tbMemWrDma;

	typedef struct packed {
		logic                sop;
		logic                eop;
		memWrDma_pkg::line_t data;
	} txLine_t;

	localparam logic [31:0] Seed = 32'hb7b68867;
	localparam logic [3:0]  RegList [4] = '{`MWD_REG_CTRL, `MWD_REG_HADDR_LO,
		`MWD_REG_HADDR_HI, `MWD_REG_LADDR};

	logic                    i_CfgClk;
	logic                    i_ARst;
	logic                    i_CfgCyc;
	logic                    i_CfgStb;
	logic                    i_CfgWnR;
	logic [3:0]              i_CfgAddr;
	memWrDma_pkg::cfgData_t  i_CfgWrData;
	wire                     o_CfgAck;
	memWrDma_pkg::cfgData_t  o_CfgRdData;
	memWrDma_pkg::pload_t    i_MaxPload;
	memWrDma_pkg::reqId_t    i_RequesterId;
	wire                     o_MemRd;
	memWrDma_pkg::lclAddr_t  o_MemRdAddr;
	logic                    i_MemReady;
	logic                    i_MemDv;
	memWrDma_pkg::line_t     i_MemRdData;
	wire                     o_AstTxDv;
	wire                     o_AstTxSop;
	wire                     o_AstTxEop;
	memWrDma_pkg::line_t     o_AstTxData;
	logic                    i_AstTxReady;

	logic [31:0] stimState;
	logic [31:0] hsState;    // LCG state for ready levels and read latency
	int          errCnt;
	int          chkCnt;
	int          toLimit;
	int          toCycles;
	int          cycleNum;
	int          lastDue;
	int          rdDue;
	string       testName;
	bit          bpOn;
	memWrDma_pkg::tag_t     tagModel;
	txLine_t                expQ [$];
	memWrDma_pkg::lclAddr_t rdAddrQ [$];
	int                     rdDueQ [$];
	memWrDma_pkg::lclAddr_t rdAddr;
	memWrDma_pkg::hostAddr_t hostArr [8];
	memWrDma_pkg::lclAddr_t  lclArr [8];
	memWrDma_pkg::byteCnt_t  lenArr [8];
	int                      mpArr [8];

	memWrDma u_dut (.*);

	bind memWrDma tbMemWrDma_assertions u_assertions
	(
		.i_Clk     (i_CfgClk),
		.i_ARst    (i_ARst),
		.i_MemRd   (o_MemRd),
		.i_TxDv    (o_AstTxDv),
		.i_TxSop   (o_AstTxSop),
		.i_TxEop   (o_AstTxEop),
		.i_TxData  (o_AstTxData),
		.i_TxReady (i_AstTxReady)
	);

	initial
	begin
		i_CfgClk = 1'b0;
		forever #4 i_CfgClk = ~i_CfgClk;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic memWrDma_pkg::line_t memLine(input memWrDma_pkg::lclAddr_t a);
		return {a, ~a};
	endfunction

	task automatic checkValue(input string what, input logic [63:0] expVal,
		input logic [63:0] actVal);
		chkCnt++;
		assert (actVal === expVal)
		else
		begin
			errCnt++;
			$display("Mismatch %s %s: expected %h, actual %h", testName, what, expVal,
				actVal);
		end
	endtask

	task automatic pushLine(input logic sop, input logic eop, input memWrDma_pkg::line_t data);
		txLine_t ln;
		ln.sop  = sop;
		ln.eop  = eop;
		ln.data = data;
		expQ.push_back(ln);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model of every line of every packet in one transfer
	////////////////////////////////////////////////////////////////////////////
	task automatic buildExpected(input memWrDma_pkg::hostAddr_t host,
		input memWrDma_pkg::lclAddr_t lcl, input memWrDma_pkg::byteCnt_t len,
		input int maxPload);
		int                  remain;
		int                  size;
		int                  nLines;
		bit                  is4;
		logic [31:0]         dw0;
		memWrDma_pkg::line_t cur;
		memWrDma_pkg::line_t prev;
		remain = int'(len);
		while (remain > 0)
		begin
			size = 128 - int'(host[6:0]);   // Up to the next host boundary
			if (size > maxPload)
				size = maxPload;
			if (size > remain)
				size = remain;
			nLines = size / 8;
			is4    = (host[63:32] != 32'd0);
			dw0    = 32'h4000_0000 | (is4 ? 32'h2000_0000 : 32'h0) | 32'(size / 4);
			pushLine(1'b1, 1'b0, {i_RequesterId, tagModel, 8'hFF, dw0});
			if (is4)
			begin
				pushLine(1'b0, 1'b0, {host[31:0], host[63:32]});
				for (int i = 0; i < nLines; i++)
					pushLine(1'b0, i == nLines - 1,
						memLine(lcl + memWrDma_pkg::lclAddr_t'(8 * i)));
			end
			else
			begin
				cur = memLine(lcl);
				pushLine(1'b0, 1'b0, {cur[31:0], host[31:0]});
				for (int i = 1; i <= nLines; i++)
				begin
					prev = memLine(lcl + memWrDma_pkg::lclAddr_t'(8 * (i - 1)));
					cur  = (i < nLines) ? memLine(lcl + memWrDma_pkg::lclAddr_t'(8 * i)) : '0;
					pushLine(1'b0, i == nLines, {cur[31:0], prev[63:32]});
				end
			end
			host     += memWrDma_pkg::hostAddr_t'(size);
			lcl      += memWrDma_pkg::lclAddr_t'(size);
			remain   -= size;
			tagModel += 8'd1;
		end
	endtask

	task automatic cfgAccess(input logic wr, input logic [3:0] addr,
		input memWrDma_pkg::cfgData_t wdata, output memWrDma_pkg::cfgData_t rdata);
		int waitCnt;
		@(posedge i_CfgClk);
		#1;
		i_CfgCyc    = 1'b1;
		i_CfgStb    = 1'b1;
		i_CfgWnR    = wr;
		i_CfgAddr   = addr;
		i_CfgWrData = wdata;
		waitCnt     = 0;
		do
		begin
			@(negedge i_CfgClk);
			waitCnt++;
		end
		while (!o_CfgAck && waitCnt < 16);
		chkCnt++;
		assert (o_CfgAck)
		else
		begin
			errCnt++;
			$display("No ack from register %0d in %s", addr, testName);
		end
		rdata = o_CfgRdData;
		@(posedge i_CfgClk);
		#1;
		i_CfgCyc = 1'b0;
		i_CfgStb = 1'b0;
		i_CfgWnR = 1'b0;
		@(negedge i_CfgClk);
		chkCnt++;
		assert (!o_CfgAck)
		else
		begin
			errCnt++;
			$display("Ack from register %0d stayed high past one cycle", addr);
		end
	endtask

	task automatic cfgWrite(input logic [3:0] addr, input memWrDma_pkg::cfgData_t wdata);
		memWrDma_pkg::cfgData_t unused;
		cfgAccess(1'b1, addr, wdata, unused);
	endtask

	task automatic cfgRead(input logic [3:0] addr, output memWrDma_pkg::cfgData_t rdata);
		cfgAccess(1'b0, addr, 32'd0, rdata);
	endtask

	task automatic runXfer(input string name, input memWrDma_pkg::hostAddr_t host,
		input memWrDma_pkg::lclAddr_t lcl, input memWrDma_pkg::byteCnt_t len,
		input int maxPload, input bit bp, input bit enable);
		memWrDma_pkg::cfgData_t rd;
		@(posedge i_CfgClk);
		#1;
		testName   = name;
		bpOn       = bp;
		i_MaxPload = memWrDma_pkg::pload_t'(maxPload);
		if (enable)
			buildExpected(host, lcl, len, maxPload);
		cfgWrite(`MWD_REG_HADDR_LO, host[31:0]);
		cfgWrite(`MWD_REG_HADDR_HI, host[63:32]);
		cfgWrite(`MWD_REG_LADDR, lcl);
		cfgWrite(`MWD_REG_CTRL, {31'd0, enable});
		cfgWrite(`MWD_REG_LEN, len);   // Start
		if (enable)
		begin
			while (expQ.size() > 0)
				@(negedge i_CfgClk);
			do
				cfgRead(`MWD_REG_STAT, rd);
			while (rd[0] != 1'b0);   // Busy clears after the last packet
		end
		else
			repeat (40) @(negedge i_CfgClk);   // Window for a stray packet
		cfgRead(`MWD_REG_STAT, rd);
		checkValue("status", 64'h2, {32'd0, rd});
		cfgRead(`MWD_REG_LEN, rd);
		checkValue("remaining", 64'h0, {32'd0, rd});
	endtask

	task automatic checkStreamLine();
		txLine_t expLn;
		chkCnt++;
		assert (expQ.size() > 0)
		else
		begin
			errCnt++;
			$display("Stream line accepted in %s with no packet expected", testName);
		end
		if (expQ.size() > 0)
		begin
			expLn = expQ.pop_front();
			checkValue("sop", {63'd0, expLn.sop}, {63'd0, o_AstTxSop});
			checkValue("eop", {63'd0, expLn.eop}, {63'd0, o_AstTxEop});
			checkValue("data", expLn.data, o_AstTxData);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory and host models sample at negedge and drive after posedge
	////////////////////////////////////////////////////////////////////////////
	always
	begin
		@(negedge i_CfgClk);
		if (!i_ARst)
		begin
			if (o_MemRd && i_MemReady)
			begin
				hsState = lcgNext(hsState);
				rdDue   = cycleNum + 1 + int'(hsState[25:24]);
				if (rdDue <= lastDue)
					rdDue = lastDue + 1;   // Keep returns in order
				lastDue = rdDue;
				rdAddrQ.push_back(o_MemRdAddr);
				rdDueQ.push_back(rdDue);
			end
			if (o_AstTxDv && i_AstTxReady)
				checkStreamLine();
		end
		@(posedge i_CfgClk);
		cycleNum++;
		#1;
		hsState      = lcgNext(hsState);
		i_AstTxReady = !bpOn || (hsState[29:28] != 2'b00);
		i_MemReady   = !bpOn || (hsState[27:26] != 2'b00);
		if (rdDueQ.size() > 0 && rdDueQ[0] <= cycleNum)
		begin
			rdAddr      = rdAddrQ.pop_front();
			rdDue       = rdDueQ.pop_front();
			i_MemDv     = 1'b1;
			i_MemRdData = memLine(rdAddr);
		end
		else
			i_MemDv = 1'b0;
	end

	initial
	begin
		wait (toLimit > 0);
		for (toCycles = 0; toCycles < toLimit; toCycles++)
			@(posedge i_CfgClk);
		$display("Timeout after %0d cycles in %s", toLimit, testName);
		$display("Checks: %0d, errors: %0d", chkCnt, errCnt);
		$display("test failed");
		$finish;
	end

	initial
	begin
		memWrDma_pkg::cfgData_t rd;
		memWrDma_pkg::cfgData_t val;
		int                     totalBytes;
		bit                     above;
		string                  nm;
		i_ARst = 1'b1;
		i_CfgCyc = 1'b0;
		i_CfgStb = 1'b0;
		i_CfgWnR = 1'b0;
		i_CfgAddr = 4'd0;
		i_CfgWrData = '0;
		i_MemReady = 1'b0;
		i_MemDv = 1'b0;
		i_MemRdData = '0;
		i_AstTxReady = 1'b0;
		i_MaxPload = 12'd128;
		errCnt = 0;
		chkCnt = 0;
		toLimit = 0;
		cycleNum = 0;
		lastDue = 0;
		bpOn = 1'b0;
		tagModel = 8'd0;
		testName = "reset";
		stimState = Seed;
		hsState = ~Seed;
		totalBytes = 0;
		stimState = lcgNext(stimState);
		i_RequesterId = stimState[31:16];
		// Tests 2, 3, 5 and 7 go above 4 GB and tests 4 to 7 see back-pressure
		for (int i = 0; i < 8; i++)
		begin
			above     = (i == 2) || (i == 3) || (i >= 4 && i % 2 == 1);
			stimState = lcgNext(stimState);
			lenArr[i] = {22'd0, stimState[22:16], 3'b000} + 32'd8;
			mpArr[i]  = 128 * (int'(stimState[9:8]) + 1);
			stimState = lcgNext(stimState);
			lclArr[i] = {stimState[31:3], 3'b000};
			stimState = lcgNext(stimState);
			hostArr[i][31:0] = {stimState[31:3], 3'b000};
			stimState = lcgNext(stimState);
			hostArr[i][63:32] = above ? (stimState | 32'd1) : 32'd0;
			totalBytes += int'(lenArr[i]);
		end
		toLimit = 4000 + totalBytes;   // About 8 cycles per line
		repeat (10) @(posedge i_CfgClk);
		#1;
		i_ARst = 1'b0;

		testName = "regs";
		cfgRead(`MWD_REG_STAT, rd);
		checkValue("status after reset", 64'h2, {32'd0, rd});
		foreach (RegList[k])
		begin
			stimState = lcgNext(stimState);
			val = stimState;
			cfgWrite(RegList[k], val);
			cfgRead(RegList[k], rd);
			checkValue("readback", {32'd0, val}, {32'd0, rd});
		end

		for (int i = 0; i < 8; i++)
		begin
			if (i < 2)
				nm = "below4g";
			else if (i < 4)
				nm = "above4g";
			else
				nm = "backpressure";
			runXfer(nm, hostArr[i], lclArr[i], lenArr[i], mpArr[i], i >= 4, 1'b1);
		end
		runXfer("disabled", hostArr[0], lclArr[0], lenArr[0], mpArr[0], 1'b0, 1'b0);

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", chkCnt, errCnt,
			u_dut.u_assertions.failCount);
		if (errCnt == 0 && u_dut.u_assertions.failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/memWrDma_pkg.sv
hw/dmaCfgRegs.sv
hw/pktSegmenter.sv
hw/memBurstReader.sv
hw/lineFifo.sv
hw/tlpFramer.sv
hw/memWrDma.sv
bench/tbMemWrDma_assertions.sv
bench/tbMemWrDma.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbMemWrDma
FILELIST  = list.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST)) hw/memWrDma_params.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
